//--- gf_inverter.sv
// inverse by a^254 in 14 serial multiplies; zero maps to zero; start while running is ignored
`timescale 1ns/1ps
`default_nettype none

module gf_inverter import gf_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     start,
  input  gf_elem_t value,
  output gf_elem_t inverse,
  output logic     done
);

  // 254 = 0b11111110 so a^254 = a^2 * a^4 * ... * a^128
  // even steps square pow_q, odd steps fold pow_q into acc_q
  localparam int num_mults = 14;

  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_issue = 2'd1;  // pulse compute
  localparam logic [1:0] s_wait  = 2'd2;  // product lands

  logic [1:0] state;
  logic [3:0] step;   // multiply count 0..13
  gf_elem_t   pow_q;  // running a^(2^i)
  gf_elem_t   acc_q;  // partial product
  gf_elem_t   value_q;
  gf_elem_t   mul_a;
  gf_elem_t   mul_b;
  gf_elem_t   mul_product;
  logic       mul_compute;
  logic       mul_done;

  assign mul_compute = (state == s_issue);
  assign mul_a       = step[0] ? acc_q : pow_q;  // square or accumulate
  assign mul_b       = pow_q;
  assign inverse     = acc_q;  // stable from done until next start

  gf_multiplier mult_inst (
    .clock   (clock),
    .reset   (reset),
    .compute (mul_compute),
    .a       (mul_a),
    .b       (mul_b),
    .product (mul_product),
    .done    (mul_done)
  );

  // sequencer, two cycles per multiply
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= s_idle;
      step  <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        s_idle:
        begin
          if (start)
          begin
            step  <= '0;
            state <= s_issue;
          end
        end
        s_issue: state <= s_wait;
        s_wait:
        begin
          if (mul_done)
          begin
            if (step == 4'(num_mults - 1))
            begin
              done  <= 1'b1;  // rises on the 28th edge after start
              state <= s_idle;
            end
            else
            begin
              step  <= step + 4'd1;
              state <= s_issue;
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // operand and result registers
  always_ff @(posedge clock)
  begin
    if (state == s_idle && start)
    begin
      pow_q   <= value;
      acc_q   <= gf_one;
      value_q <= value;
    end
    else if (state == s_wait && mul_done)
    begin
      if (step[0])
        acc_q <= mul_product;
      else
        pow_q <= mul_product;
    end
  end

  // held result really is the inverse of the sampled input
  a_inverse_ok: assert property (
    @(posedge clock) disable iff (reset)
    (done && value_q != '0) |-> gf_mul(value_q, inverse) == gf_one
  );

endmodule

`default_nettype wire

//--- gf_multiplier.sv
// product registers on compute and holds otherwise; done pulses one cycle and there is no busy
`timescale 1ns/1ps
`default_nettype none

module gf_multiplier import gf_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     compute,  // sample a and b this edge
  input  gf_elem_t a,
  input  gf_elem_t b,
  output gf_elem_t product,
  output logic     done
);

  // col[k] holds a * alpha^k as column k of the reduction matrix
  gf_elem_t col [gf_width];
  gf_elem_t prod_comb;

  always_comb
  begin
    col[0] = a;
    for (int k = 1; k < gf_width; k++)
    begin
      col[k] = gf_xtime(col[k-1]);  // each column one alpha step up
    end
    // b bits gate the columns and xor sums them
    prod_comb = '0;
    for (int k = 0; k < gf_width; k++)
    begin
      prod_comb ^= col[k] & {gf_width{b[k]}};
    end
  end

  // result register
  always_ff @(posedge clock)
  begin
    if (compute)
    begin
      product <= prod_comb;
    end
  end

  // done follows compute by one edge
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= compute;  // back to back computes keep it high
    end
  end

  // registered result equals the field product taken with a and b swapped
  a_product_correct: assert property (
    @(posedge clock) disable iff (reset)
    compute |=> product == gf_mul($past(b), $past(a))
  );

endmodule

`default_nettype wire

//--- gf_pkg.sv
// GF(2^8) over x^8+x^4+x^3+x^2+1; gf_mul is a plain loop meant for models and checks
`default_nettype none

package gf_pkg;

  localparam int gf_width = 8;  // bits per field element

  typedef logic [gf_width-1:0] gf_elem_t;

  // low byte of 0x11D, the x^8 term is implied
  localparam gf_elem_t gf_poly = 8'h1D;
  localparam gf_elem_t gf_one  = 8'h01;

  // multiply by alpha, one column step of the multiplier matrix
  function automatic gf_elem_t gf_xtime(input gf_elem_t x);
    if (x[gf_width-1])
      return {x[gf_width-2:0], 1'b0} ^ gf_poly;  // fold x^8 back in
    return {x[gf_width-2:0], 1'b0};
  endfunction

  // shift-and-add product, used by assertions
  function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
    gf_elem_t acc;
    gf_elem_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < gf_width; i++)
    begin
      if (b[i])
        acc ^= sh;
      sh = gf_xtime(sh);
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

//--- gf_poly_divider_top.f
gf_pkg.sv
gf_multiplier.sv
gf_inverter.sv
poly_divider.sv
gf_poly_divider_top.sv
tb_gf_poly_divider_top.sv

//--- gf_poly_divider_top.sv
// top level of the division step only; timing and limits are those of poly_divider
`timescale 1ns/1ps
`default_nettype none

module gf_poly_divider_top import gf_pkg::*; #(
  parameter  int MAX_DEGREE = 16,
  localparam int idx_w      = $clog2(MAX_DEGREE + 1)
) (
  input  logic             clock,
  input  logic             reset,
  // coefficient load
  input  logic             load,
  input  logic             load_divisor,
  input  logic [idx_w-1:0] load_index,
  input  gf_elem_t         load_coef,
  // operand degrees
  input  logic [idx_w-1:0] dividend_degree,
  input  logic [idx_w-1:0] divisor_degree,
  // run control
  input  logic             start,
  output logic             busy,
  output logic             done,
  output logic             divide_error,
  // readback
  input  logic [idx_w-1:0] read_index,
  output gf_elem_t         quotient_coef,
  output gf_elem_t         remainder_coef
);

  poly_divider #(
    .MAX_DEGREE (MAX_DEGREE)
  ) poly_divider_inst (
    .clock           (clock),
    .reset           (reset),
    .load            (load),
    .load_divisor    (load_divisor),
    .load_index      (load_index),
    .load_coef       (load_coef),
    .dividend_degree (dividend_degree),
    .divisor_degree  (divisor_degree),
    .start           (start),
    .busy            (busy),
    .done            (done),
    .divide_error    (divide_error),
    .read_index      (read_index),
    .quotient_coef   (quotient_coef),
    .remainder_coef  (remainder_coef)
  );

endmodule

`default_nettype wire

//--- poly_divider.sv
// degrees at most MAX_DEGREE; reload the dividend before each run since it is divided in place
`timescale 1ns/1ps
`default_nettype none

module poly_divider import gf_pkg::*; #(
  parameter  int MAX_DEGREE = 16,
  localparam int idx_w      = $clog2(MAX_DEGREE + 1)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             load,             // write one coefficient
  input  logic             load_divisor,     // 1 divisor, 0 dividend
  input  logic [idx_w-1:0] load_index,
  input  gf_elem_t         load_coef,
  input  logic [idx_w-1:0] dividend_degree,
  input  logic [idx_w-1:0] divisor_degree,
  input  logic             start,
  output logic             busy,
  output logic             done,
  output logic             divide_error,     // zero leading divisor coef
  input  logic [idx_w-1:0] read_index,
  output gf_elem_t         quotient_coef,
  output gf_elem_t         remainder_coef
);

  localparam logic [idx_w-1:0] last_idx = idx_w'(MAX_DEGREE);

  localparam logic [2:0] s_idle     = 3'd0;
  localparam logic [2:0] s_inv      = 3'd1;  // start inverter
  localparam logic [2:0] s_inv_wait = 3'd2;
  localparam logic [2:0] s_quo      = 3'd3;  // lead rem times inverse
  localparam logic [2:0] s_quo_wait = 3'd4;
  localparam logic [2:0] s_sub      = 3'd5;  // q times divisor coef j
  localparam logic [2:0] s_sub_wait = 3'd6;

  gf_elem_t rem_mem [0:MAX_DEGREE];  // dividend and later remainder
  gf_elem_t div_mem [0:MAX_DEGREE];
  gf_elem_t quo_mem [0:MAX_DEGREE];

  logic [2:0]       state;
  logic [idx_w-1:0] n_q;  // latched dividend degree
  logic [idx_w-1:0] d_q;  // latched divisor degree
  logic [idx_w-1:0] pos;  // current leading remainder position
  logic [idx_w-1:0] j;    // divisor coef in the subtract loop
  gf_elem_t         q_q;  // current quotient coef
  logic [idx_w-1:0] quo_idx;
  logic [idx_w-1:0] sub_idx;
  logic             accept;
  logic             lead_zero;
  logic             last_sub;
  logic             last_step;
  logic             step_end;

  gf_elem_t mul_a;
  gf_elem_t mul_b;
  gf_elem_t mul_product;
  logic     mul_compute;
  logic     mul_done;
  gf_elem_t inv_in;
  gf_elem_t inv_out;
  logic     inv_start;
  logic     inv_done;

  assign accept    = start && !busy;  // start during a run is dropped
  assign quo_idx   = pos - d_q;
  assign sub_idx   = quo_idx + j;     // remainder slot hit by divisor coef j
  assign inv_in    = div_mem[d_q];
  assign lead_zero = (inv_in == '0);
  assign last_sub  = (j == d_q - 1'b1);
  assign last_step = (pos == d_q);

  // a step ends after the quotient multiply when the divisor is a constant
  assign step_end = mul_done &&
                    ((state == s_quo_wait && d_q == '0) ||
                     (state == s_sub_wait && last_sub));

  assign inv_start   = (state == s_inv);
  assign mul_compute = (state == s_quo) || (state == s_sub);
  assign mul_a       = (state == s_quo) ? rem_mem[pos] : q_q;
  assign mul_b       = (state == s_quo) ? inv_out : div_mem[j];

  gf_multiplier mult_inst (
    .clock   (clock),
    .reset   (reset),
    .compute (mul_compute),
    .a       (mul_a),
    .b       (mul_b),
    .product (mul_product),
    .done    (mul_done)
  );

  gf_inverter inv_inst (
    .clock   (clock),
    .reset   (reset),
    .start   (inv_start),
    .value   (inv_in),
    .inverse (inv_out),  // held for the whole run
    .done    (inv_done)
  );

  // sequencer
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state        <= s_idle;
      busy         <= 1'b0;
      done         <= 1'b0;
      divide_error <= 1'b0;
      pos          <= '0;
      j            <= '0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        s_idle:
        begin
          if (accept)
          begin
            busy         <= 1'b1;
            divide_error <= 1'b0;  // error level lasts until next start
            state        <= s_inv;
          end
        end
        s_inv: state <= s_inv_wait;
        s_inv_wait:
        begin
          if (inv_done)
          begin
            if (lead_zero)
            begin
              divide_error <= 1'b1;
              busy         <= 1'b0;
              done         <= 1'b1;
              state        <= s_idle;
            end
            else if (d_q > n_q)
            begin
              busy  <= 1'b0;  // nothing to divide so the remainder is the dividend
              done  <= 1'b1;
              state <= s_idle;
            end
            else
            begin
              pos   <= n_q;
              state <= s_quo;
            end
          end
        end
        s_quo: state <= s_quo_wait;
        s_quo_wait:
        begin
          if (mul_done && d_q != '0)
          begin
            j     <= '0;
            state <= s_sub;
          end
        end
        s_sub: state <= s_sub_wait;
        s_sub_wait:
        begin
          if (mul_done && !last_sub)
          begin
            j     <= j + 1'b1;
            state <= s_sub;
          end
        end
        default: state <= s_idle;
      endcase

      if (step_end)
      begin
        if (last_step)
        begin
          busy  <= 1'b0;  // falls together with done
          done  <= 1'b1;
          state <= s_idle;
        end
        else
        begin
          pos   <= pos - 1'b1;
          state <= s_quo;
        end
      end
    end
  end

  // coefficient storage and degree latches
  always_ff @(posedge clock)
  begin
    if (load && !busy)
    begin
      if (load_divisor)
        div_mem[load_index] <= load_coef;
      else
        rem_mem[load_index] <= load_coef;
    end
    if (accept)
    begin
      n_q <= dividend_degree;
      d_q <= divisor_degree;
      for (int i = 0; i <= MAX_DEGREE; i++)
      begin
        quo_mem[i] <= '0;
        if (idx_w'(i) > dividend_degree)
          rem_mem[i] <= '0;  // drop stale coefs above the dividend
      end
    end
    if (state == s_quo_wait && mul_done)
    begin
      q_q              <= mul_product;
      quo_mem[quo_idx] <= mul_product;
      rem_mem[pos]     <= '0;  // leading term cancels by construction
    end
    if (state == s_sub_wait && mul_done)
    begin
      rem_mem[sub_idx] <= rem_mem[sub_idx] ^ mul_product;  // subtract is xor
    end
  end

  assign quotient_coef  = (read_index <= last_idx) ? quo_mem[read_index] : '0;
  assign remainder_coef = (read_index <= last_idx) ? rem_mem[read_index] : '0;

  // quotient coef times the divisor lead gives back the leading remainder term
  a_lead_cancels: assert property (
    @(posedge clock) disable iff (reset)
    (state == s_quo_wait && mul_done) |-> gf_mul(mul_product, div_mem[d_q]) == rem_mem[pos]
  );

  // done only with busy low and one cycle wide
  a_done_pulse: assert property (
    @(posedge clock) disable iff (reset)
    done |-> !busy ##1 !done
  );

  // every run ends with done
  a_busy_fall: assert property (
    @(posedge clock) disable iff (reset)
    $fell(busy) |-> done
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile with verilator and run; the exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_gf_poly_divider_top \
  -f gf_poly_divider_top.f \
  --Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb

//--- tb_gf_poly_divider_top.sv
// directed tests at MAX_DEGREE 16; every run reloads its operands since the DUT divides in place
`timescale 1ns/1ps
`default_nettype none

module tb_gf_poly_divider_top import gf_pkg::*; ();

  localparam int max_degree     = 16;
  localparam int idx_w          = $clog2(max_degree + 1);
  localparam int timeout_cycles = 2000;  // longest run is well under 700 cycles

  logic             clock;
  logic             reset;
  logic             load;
  logic             load_divisor;
  logic [idx_w-1:0] load_index;
  gf_elem_t         load_coef;
  logic [idx_w-1:0] dividend_degree;
  logic [idx_w-1:0] divisor_degree;
  logic             start;
  logic             busy;
  logic             done;
  logic             divide_error;
  logic [idx_w-1:0] read_index;
  gf_elem_t         quotient_coef;
  gf_elem_t         remainder_coef;

  gf_elem_t    dvd   [0:max_degree];    // dividend under test
  gf_elem_t    dvs   [0:max_degree];    // divisor under test
  gf_elem_t    exp_q [0:max_degree];    // model quotient
  gf_elem_t    exp_r [0:max_degree];    // model remainder
  gf_elem_t    fac   [0:max_degree];    // left factor for poly multiply
  gf_elem_t    prod  [0:2*max_degree];  // fac times divisor
  logic [31:0] lcg_state;

  gf_poly_divider_top #(
    .MAX_DEGREE (max_degree)
  ) gf_poly_divider_top_inst (
    .clock           (clock),
    .reset           (reset),
    .load            (load),
    .load_divisor    (load_divisor),
    .load_index      (load_index),
    .load_coef       (load_coef),
    .dividend_degree (dividend_degree),
    .divisor_degree  (divisor_degree),
    .start           (start),
    .busy            (busy),
    .done            (done),
    .divide_error    (divide_error),
    .read_index      (read_index),
    .quotient_coef   (quotient_coef),
    .remainder_coef  (remainder_coef)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic gf_elem_t rand_byte();
    logic [31:0] v;
    v = lcg_next();
    return v[23:16];  // upper bits since low ones cycle fast
  endfunction

  function automatic int rand_below(input int span);
    return int'(lcg_next() >> 16) % span;
  endfunction

  // shift and reduce multiply on gf_poly
  function automatic gf_elem_t ref_mul(input gf_elem_t a, input gf_elem_t b);
    gf_elem_t p;
    gf_elem_t x;
    gf_elem_t y;
    p = '0;
    x = a;
    y = b;
    while (y != '0)
    begin
      if (y[0])
        p = p ^ x;
      x = x[7] ? ({x[6:0], 1'b0} ^ gf_poly) : {x[6:0], 1'b0};
      y = {1'b0, y[7:1]};
    end
    return p;
  endfunction

  // inverse by exhaustive search and zero maps to zero
  function automatic gf_elem_t ref_inv(input gf_elem_t a);
    for (int b = 1; b < 256; b++)
    begin
      if (ref_mul(a, 8'(b)) == gf_one)
        return 8'(b);
    end
    return '0;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input gf_elem_t expv, input gf_elem_t actv);
    $display("Mismatch in %s %s expected %h actual %h", name, what, expv, actv);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  // reference long division into exp_q and exp_r
  task automatic model_divide(input int n, input int d);
    gf_elem_t inv;
    gf_elem_t c;
    for (int i = 0; i <= max_degree; i++)
    begin
      exp_q[i] = '0;
      exp_r[i] = (i <= n) ? dvd[i] : '0;
    end
    if (d <= n)
    begin
      inv = ref_inv(dvs[d]);
      for (int p = n; p >= d; p--)
      begin
        c = ref_mul(exp_r[p], inv);  // next quotient coef
        exp_q[p-d] = c;
        for (int k = 0; k <= d; k++)
          exp_r[p-d+k] = exp_r[p-d+k] ^ ref_mul(c, dvs[k]);
      end
    end
  endtask

  task automatic mul_by_divisor(input int fd, input int d);
    for (int i = 0; i <= 2 * max_degree; i++)
      prod[i] = '0;
    for (int a = 0; a <= fd; a++)
      for (int b = 0; b <= d; b++)
        prod[a+b] = prod[a+b] ^ ref_mul(fac[a], dvs[b]);
  endtask

  // q times divisor plus r must give back the dividend with r below the divisor degree
  task automatic check_model(input string name, input int n, input int d);
    gf_elem_t want;
    gf_elem_t got;
    for (int i = 0; i <= max_degree; i++)
      fac[i] = exp_q[i];
    mul_by_divisor(max_degree, d);
    for (int i = 0; i <= 2 * max_degree; i++)
    begin
      want = (i <= n) ? dvd[i] : '0;
      got  = prod[i] ^ ((i <= max_degree) ? exp_r[i] : '0);
      assert (got == want)
        else stop_run($sformatf("%s model q*d+r differs from dividend at %0d", name, i));
      if (i >= d && i <= max_degree)
        assert (exp_r[i] == '0)
          else stop_run($sformatf("%s model remainder left at %0d", name, i));
    end
  endtask

  task automatic write_coef(input logic to_divisor, input int idx, input gf_elem_t c);
    @(negedge clock);
    load         = 1'b1;
    load_divisor = to_divisor;
    load_index   = idx_w'(idx);
    load_coef    = c;
  endtask

  task automatic load_operands(input int n, input int d);
    for (int i = 0; i <= n; i++)
      write_coef(1'b0, i, dvd[i]);
    for (int i = 0; i <= d; i++)
      write_coef(1'b1, i, dvs[i]);
    @(negedge clock);
    load = 1'b0;
  endtask

  task automatic start_run(input int n, input int d);
    @(negedge clock);
    dividend_degree = idx_w'(n);
    divisor_degree  = idx_w'(d);
    start           = 1'b1;
    @(negedge clock);
    start = 1'b0;  // single cycle pulse
  endtask

  task automatic finish_run(input string name, input logic exp_error);
    int cycles;
    cycles = 0;
    while (done !== 1'b1)
    begin
      if (cycles == timeout_cycles)
        stop_run($sformatf("%s got no done within %0d cycles", name, timeout_cycles));
      @(negedge clock);
      cycles++;
    end
    assert (busy == 1'b0)
      else stop_run($sformatf("%s saw busy still high together with done", name));
    assert (divide_error == exp_error)
      else report_mismatch(name, "divide_error", 8'(exp_error), 8'(divide_error));
  endtask

  // read every index back after the combinational read settles
  task automatic check_results(input string name, input int d);
    for (int i = 0; i <= max_degree; i++)
    begin
      @(negedge clock);
      read_index = idx_w'(i);
      #1;
      if (i >= d)
        assert (remainder_coef == '0)
          else report_mismatch(name, $sformatf("remainder[%0d] at or above divisor degree", i),
                               '0, remainder_coef);
      assert (quotient_coef == exp_q[i])
        else report_mismatch(name, $sformatf("quotient[%0d]", i), exp_q[i], quotient_coef);
      assert (remainder_coef == exp_r[i])
        else report_mismatch(name, $sformatf("remainder[%0d]", i), exp_r[i], remainder_coef);
    end
  endtask

  task automatic run_and_check(input string name, input int n, input int d);
    model_divide(n, d);
    check_model(name, n, d);
    load_operands(n, d);
    start_run(n, d);
    finish_run(name, 1'b0);
    check_results(name, d);
  endtask

  task automatic test_reset_state();
    @(negedge clock);
    assert (busy == 1'b0) else report_mismatch("reset_state", "busy", 8'd0, 8'(busy));
    assert (done == 1'b0) else report_mismatch("reset_state", "done", 8'd0, 8'(done));
    assert (divide_error == 1'b0)
      else report_mismatch("reset_state", "divide_error", 8'd0, 8'(divide_error));
  endtask

  // divisor (x+a)(x+a^2) with a = 2
  task automatic test_known_division();
    gf_elem_t a1;
    gf_elem_t a2;
    a1     = 8'h02;
    a2     = ref_mul(a1, a1);
    dvs[0] = ref_mul(a1, a2);
    dvs[1] = a1 ^ a2;
    dvs[2] = gf_one;  // monic
    dvd[0] = 8'h12;
    dvd[1] = 8'h34;
    dvd[2] = 8'h56;
    dvd[3] = 8'h78;
    dvd[4] = 8'h9a;
    dvd[5] = 8'hbc;
    dvd[6] = 8'hde;
    run_and_check("known_fixed", 6, 2);
    // exact multiple of the divisor
    for (int i = 0; i <= max_degree; i++)
      fac[i] = (i <= 4) ? 8'(5 - i) : '0;
    mul_by_divisor(4, 2);
    for (int i = 0; i <= 6; i++)
      dvd[i] = prod[i];
    model_divide(6, 2);
    for (int i = 0; i <= max_degree; i++)
    begin
      assert (exp_r[i] == '0) else report_mismatch("known_multiple", "model rem", '0, exp_r[i]);
      assert (exp_q[i] == fac[i])
        else report_mismatch("known_multiple", "model quo", fac[i], exp_q[i]);
    end
    run_and_check("known_multiple", 6, 2);
  endtask

  task automatic test_random_operands();
    int n;
    int d;
    for (int t = 0; t < 20; t++)
    begin
      n = rand_below(max_degree + 1);
      d = rand_below(n + 1);
      for (int i = 0; i <= max_degree; i++)
      begin
        dvd[i] = rand_byte();
        dvs[i] = rand_byte();
      end
      if (dvs[d] == '0)
        dvs[d] = gf_one;  // keep the lead nonzero
      run_and_check($sformatf("random_%0d", t), n, d);
    end
  endtask

  task automatic test_divisor_higher();
    for (int i = 0; i <= max_degree; i++)
    begin
      dvd[i] = rand_byte();
      dvs[i] = rand_byte() | 8'h01;
    end
    run_and_check("divisor_higher", 3, 7);  // quotient zero and remainder is dividend
  endtask

  task automatic test_zero_leading();
    for (int i = 0; i <= max_degree; i++)
    begin
      dvd[i] = rand_byte();
      dvs[i] = rand_byte() | 8'h01;
    end
    dvs[4] = '0;
    load_operands(8, 4);
    start_run(8, 4);
    finish_run("zero_leading", 1'b1);
    dvs[4] = 8'h3c;  // valid run must clear the error
    run_and_check("zero_leading_recover", 8, 4);
  endtask

  task automatic test_start_while_busy();
    for (int i = 0; i <= max_degree; i++)
    begin
      dvd[i] = rand_byte();
      dvs[i] = rand_byte() | 8'h01;
    end
    model_divide(12, 5);
    check_model("start_while_busy", 12, 5);
    load_operands(12, 5);
    start_run(12, 5);
    assert (busy == 1'b1)
      else stop_run("start_while_busy saw busy low right after start");
    // second start with other degrees and a stray load must both be ignored
    @(negedge clock);
    start           = 1'b1;
    dividend_degree = idx_w'(2);
    divisor_degree  = idx_w'(1);
    load            = 1'b1;
    load_divisor    = 1'b1;
    load_index      = '0;
    load_coef       = ~dvs[0];
    repeat (2) @(negedge clock);
    start = 1'b0;
    load  = 1'b0;
    finish_run("start_while_busy", 1'b0);
    check_results("start_while_busy", 5);
  endtask

  initial
  begin
    lcg_state       = 32'd70;
    reset           = 1'b1;
    load            = 1'b0;
    load_divisor    = 1'b0;
    load_index      = '0;
    load_coef       = '0;
    dividend_degree = '0;
    divisor_degree  = '0;
    start           = 1'b0;
    read_index      = '0;
    repeat (4) @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_known_division();
    test_random_operands();
    test_divisor_higher();
    test_zero_leading();
    test_start_while_busy();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
